// File: Makefile
# Verilator simulation of the ECC register file
VERILATOR ?= verilator
TOP       ?= tb_rf_ecc_top
FILELIST  ?= rf_ecc_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

.PHONY: sim clean

# Build, run from the project root, then look for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /^$(PASS_MSG)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

// File: include/rf_config.svh
// Sizes of the ECC register file; the port count may change but widths assume 32-bit SECDED
`ifndef RF_CONFIG_SVH
`define RF_CONFIG_SVH

// Number of independent read ports
`define RF_NUM_READ_PORTS 2

// Register index width
`define RF_ADDR_W 5

// Data word width
`define RF_DATA_W 32

// Check bits per word, six Hamming plus one overall parity
`define RF_ECC_W 7

// Architectural registers including the hardwired x0
`define RF_NUM_REGS 32

`endif

// File: rf_ecc_top.f
+incdir+include
rtl/rf_pkg.sv
rtl/rf_ecc_encoder.sv
rtl/rf_storage.sv
rtl/rf_read_port.sv
rtl/rf_alert.sv
rtl/rf_ecc_top.sv
sim/tb_rf_ecc_top.sv

// File: rtl/rf_alert.sv
// Alert collector for all read ports; the major alert can only be cleared by rst_i
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_alert (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Error classes from every read port
  input  logic [`RF_NUM_READ_PORTS-1:0] err_single_i,
  input  logic [`RF_NUM_READ_PORTS-1:0] err_double_i,
  // Security alerts
  output logic                          alert_minor_o,
  output logic                          alert_major_o
);

  logic any_single;
  logic any_double;
  logic minor_q;
  logic major_q;

  // Any port is enough
  assign any_single = |err_single_i;
  assign any_double = |err_double_i;

  //////////////////////////////////////////////////
  // Alert registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      minor_q <= 1'b0;
      major_q <= 1'b0;
    end else begin
      // Corrected error, one pulse per cycle with a flag
      minor_q <= any_single;
      // Uncorrectable error latches until reset
      major_q <= major_q || any_double;
    end
  end

  assign alert_minor_o = minor_q;
  assign alert_major_o = major_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Sticky across any later clean traffic
  a_major_sticky : assert property (
    @(posedge clk_i)
    $fell(alert_major_o) |-> $past(rst_i)
  ) else $error("alert_major_o dropped without reset");

endmodule

// File: rtl/rf_ecc_encoder.sv
// Purely combinational SECDED encoder; rst_i only qualifies the checks, winj_i must be zero in use
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_ecc_encoder (
  input  logic             clk_i,
  input  logic             rst_i,
  // Write request from outside
  input  logic             we_i,
  input  rf_pkg::rf_addr_t waddr_i,
  input  rf_pkg::rf_data_t wdata_i,
  // Fault injection mask, XORed into the stored word
  input  rf_pkg::rf_cword_t winj_i,
  // Encoded write towards the storage
  output logic             we_o,
  output rf_pkg::rf_addr_t waddr_o,
  output rf_pkg::rf_cword_t wcword_o
);

  import rf_pkg::*;

  logic [RF_HAM_W-1:0] ham;
  logic                parity;
  rf_ecc_t             ecc;

  //////////////////////////////////////////////////
  // Check bit generation
  //////////////////////////////////////////////////

  always_comb begin
    // Each Hamming bit covers a fixed group of data bits
    for (int unsigned k = 0; k < RF_HAM_W; k++) begin
      ham[k] = ^(wdata_i & rf_ham_mask(k));
    end
    // Even parity over data and Hamming bits
    parity = ^{ham, wdata_i};
  end

  // Overall parity sits in the top check bit
  assign ecc = {parity, ham};

  // Injection flips chosen bits of the finished codeword
  assign wcword_o = {ecc, wdata_i} ^ winj_i;

  // Control passes straight through, no pipelining on the write side
  assign we_o    = we_i;
  assign waddr_o = waddr_i;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // An unknown address would corrupt an unknown register
  a_waddr_known : assert property (
    @(posedge clk_i) disable iff (rst_i)
    we_i |-> !$isunknown(waddr_i)
  ) else $error("write address unknown while we_i is high");

endmodule

// File: rtl/rf_ecc_top.sv
// ECC register file top; reads return data one cycle after re_i and never stall
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_ecc_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Write port
  input  logic                          we_i,
  input  rf_pkg::rf_addr_t              waddr_i,
  input  rf_pkg::rf_data_t              wdata_i,
  input  rf_pkg::rf_cword_t             winj_i,
  // Read requests
  input  logic [`RF_NUM_READ_PORTS-1:0] re_i,
  input  rf_pkg::rf_addr_t              raddr_i  [`RF_NUM_READ_PORTS],
  // Read results
  output rf_pkg::rf_data_t              rdata_o  [`RF_NUM_READ_PORTS],
  output logic [`RF_NUM_READ_PORTS-1:0] rvalid_o,
  // Security alerts
  output logic                          alert_minor_o,
  output logic                          alert_major_o
);

  import rf_pkg::*;

  // Encoder to storage
  logic                          enc_we;
  rf_addr_t                      enc_waddr;
  rf_cword_t                     enc_wcword;

  // Storage to read ports
  rf_cword_t                     rd_cword [`RF_NUM_READ_PORTS];

  // Read ports to alert unit
  logic [`RF_NUM_READ_PORTS-1:0] err_single;
  logic [`RF_NUM_READ_PORTS-1:0] err_double;

  //////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////

  rf_ecc_encoder encoder_i (
    .clk_i    ( clk_i      ),
    .rst_i    ( rst_i      ),
    .we_i     ( we_i       ),
    .waddr_i  ( waddr_i    ),
    .wdata_i  ( wdata_i    ),
    .winj_i   ( winj_i     ),
    .we_o     ( enc_we     ),
    .waddr_o  ( enc_waddr  ),
    .wcword_o ( enc_wcword )
  );

  rf_storage storage_i (
    .clk_i    ( clk_i      ),
    .rst_i    ( rst_i      ),
    .we_i     ( enc_we     ),
    .waddr_i  ( enc_waddr  ),
    .wcword_i ( enc_wcword ),
    .raddr_i  ( raddr_i    ),
    .rcword_o ( rd_cword   )
  );

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // Same decoder replicated once per port
  for (genvar p = 0; p < `RF_NUM_READ_PORTS; p++) begin : g_read_port
    rf_read_port #(
      .PORT_ID ( p )
    ) read_port_i (
      .clk_i        ( clk_i         ),
      .rst_i        ( rst_i         ),
      .re_i         ( re_i[p]       ),
      .cword_i      ( rd_cword[p]   ),
      .rvalid_o     ( rvalid_o[p]   ),
      .rdata_o      ( rdata_o[p]    ),
      .err_single_o ( err_single[p] ),
      .err_double_o ( err_double[p] )
    );
  end

  // Alert unit drains every port's flags
  rf_alert alert_i (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .err_single_i  ( err_single    ),
    .err_double_i  ( err_double    ),
    .alert_minor_o ( alert_minor_o ),
    .alert_major_o ( alert_major_o )
  );

endmodule

// File: rtl/rf_pkg.sv
// Types and Hamming helpers for the ECC register file; helpers are meant for constant arguments
`include "rf_config.svh"

package rf_pkg;

  // Hamming bits only, without the overall parity bit
  localparam int unsigned RF_HAM_W = `RF_ECC_W - 1;

  typedef logic [`RF_ADDR_W-1:0]            rf_addr_t;
  typedef logic [`RF_DATA_W-1:0]            rf_data_t;
  typedef logic [`RF_ECC_W-1:0]             rf_ecc_t;
  // Check bits on top, data in the low bits
  typedef logic [`RF_DATA_W+`RF_ECC_W-1:0]  rf_cword_t;

  // Hamming position of data bit idx
  // Positions that are powers of two belong to the Hamming bits
  function automatic logic [RF_HAM_W-1:0] rf_data_pos(int unsigned idx);
    int unsigned cnt;
    int unsigned pos;
    cnt = 0;
    pos = 0;
    for (int unsigned p = 1; p < 64; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (cnt == idx) pos = p;
        cnt++;
      end
    end
    return RF_HAM_W'(pos);
  endfunction

  // Data bits covered by Hamming bit k
  function automatic rf_data_t rf_ham_mask(int unsigned k);
    rf_data_t mask;
    mask = '0;
    for (int unsigned i = 0; i < `RF_DATA_W; i++) begin
      mask[i] = ((rf_data_pos(i) >> k) & 1'b1) != 0;
    end
    return mask;
  endfunction

endpackage

// File: rtl/rf_read_port.sv
// One-cycle SECDED read stage; rdata_o is meaningless on a double error or without rvalid_o
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_read_port #(
  parameter int PORT_ID = 0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // Request strobe and the codeword fetched for it
  input  logic              re_i,
  input  rf_pkg::rf_cword_t cword_i,
  // Decoded result, one cycle after the request
  output logic              rvalid_o,
  output rf_pkg::rf_data_t  rdata_o,
  // Error class of the current result
  output logic              err_single_o,
  output logic              err_double_o
);

  import rf_pkg::*;

  logic                rvalid_q;
  rf_cword_t           cword_q;
  logic [RF_HAM_W-1:0] syndrome;
  logic                parity_err;
  logic                syn_nonzero;

  //////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////

  // Valid strobe is control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= re_i;
    end
  end

  // Captured every cycle
  // Only looked at while rvalid_q is set
  always_ff @(posedge clk_i) begin
    cword_q <= cword_i;
  end

  //////////////////////////////////////////////////
  // Syndrome and parity
  //////////////////////////////////////////////////

  always_comb begin
    // Recompute each group and compare against its stored bit
    for (int unsigned k = 0; k < RF_HAM_W; k++) begin
      syndrome[k] = cword_q[`RF_DATA_W+k] ^ (^(cword_q[`RF_DATA_W-1:0] & rf_ham_mask(k)));
    end
  end

  // Whole word carries even parity when intact
  assign parity_err  = ^cword_q;
  assign syn_nonzero = |syndrome;

  //////////////////////////////////////////////////
  // Correction
  //////////////////////////////////////////////////

  always_comb begin
    // Flip the data bit named by the syndrome
    // A syndrome pointing at a Hamming bit leaves data untouched
    for (int unsigned i = 0; i < `RF_DATA_W; i++) begin
      rdata_o[i] = cword_q[i] ^ (parity_err && (syndrome == rf_data_pos(i)));
    end
  end

  //////////////////////////////////////////////////
  // Classification
  //////////////////////////////////////////////////

  assign rvalid_o = rvalid_q;

  // Odd number of flips, treated as one and corrected
  assign err_single_o = rvalid_q && parity_err;

  // Parity intact but groups disagree, two flips
  assign err_double_o = rvalid_q && !parity_err && syn_nonzero;

  // Classes are exclusive and tied to a live result
  a_err_flags : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(err_single_o && err_double_o) && ((err_single_o || err_double_o) -> rvalid_o)
  ) else $error("read port %0d raised inconsistent error flags", PORT_ID);

endmodule

// File: rtl/rf_storage.sv
// Codeword array with one write port; contents survive reset and x0 always reads the zero word
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_storage (
  input  logic              clk_i,
  input  logic              rst_i,
  // Encoded write
  input  logic              we_i,
  input  rf_pkg::rf_addr_t  waddr_i,
  input  rf_pkg::rf_cword_t wcword_i,
  // Combinational read ports
  input  rf_pkg::rf_addr_t  raddr_i  [`RF_NUM_READ_PORTS],
  output rf_pkg::rf_cword_t rcword_o [`RF_NUM_READ_PORTS]
);

  import rf_pkg::*;

  // Entry 0 has no storage at all
  rf_cword_t mem_q [1:`RF_NUM_REGS-1];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    // Writes to x0 are dropped
    if (we_i && (waddr_i != '0)) begin
      mem_q[waddr_i] <= wcword_i;
    end
  end

  //////////////////////////////////////////////////
  // Read muxes
  //////////////////////////////////////////////////

  for (genvar p = 0; p < `RF_NUM_READ_PORTS; p++) begin : g_rd
    // All-zero word is the valid codeword of zero data
    assign rcword_o[p] = (raddr_i[p] == '0) ? '0 : mem_q[raddr_i[p]];
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // An unknown codeword would sit in the array until it is rewritten
  a_wcword_known : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (we_i && (waddr_i != '0)) |-> !$isunknown(wcword_i)
  ) else $error("write codeword unknown while we_i is high");

endmodule

// File: sim/rf_ecc_trace.txt
# name rst we waddr wdata winj re0 raddr0 re1 raddr1 v0 data0 v1 data1 minor major dc (hex)
# Expected columns hold the outputs half a cycle after the edge that samples the row
idle_after_reset 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
read_x0 0 0 00 00000000 0000000000 1 00 1 00 1 00000000 1 00000000 0 0 0
write_x1 0 1 01 12345678 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
write_x2 0 1 02 a5a5a5a5 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
write_x3 0 1 03 deadbeef 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
write_x31 0 1 1f 0f0f0f0f 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
write_x0 0 1 00 ffffffff 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
read_x1_x2 0 0 00 00000000 0000000000 1 01 1 02 1 12345678 1 a5a5a5a5 0 0 0
read_x3_x31 0 0 00 00000000 0000000000 1 03 1 1f 1 deadbeef 1 0f0f0f0f 0 0 0
read_x0_after_wr 0 0 00 00000000 0000000000 1 00 1 00 1 00000000 1 00000000 0 0 0
rw_same_x1 0 1 01 cafef00d 0000000000 1 01 1 02 1 12345678 1 a5a5a5a5 0 0 0
read_new_x1 0 0 00 00000000 0000000000 1 01 1 01 1 cafef00d 1 cafef00d 0 0 0
inj_data_x4 0 1 04 13579bdf 0000000010 0 00 0 00 0 00000000 0 00000000 0 0 0
read_inj_data 0 0 00 00000000 0000000000 1 04 0 00 1 13579bdf 0 00000000 0 0 0
minor_pulse_data 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 1 0 0
minor_off_data 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
inj_ham_x5 0 1 05 2468ace0 0400000000 0 00 0 00 0 00000000 0 00000000 0 0 0
read_inj_ham 0 0 00 00000000 0000000000 0 00 1 05 0 00000000 1 2468ace0 0 0 0
minor_pulse_ham 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 1 0 0
inj_par_x6 0 1 06 89abcdef 4000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
read_inj_par 0 0 00 00000000 0000000000 1 06 0 00 1 89abcdef 0 00000000 0 0 0
minor_pulse_par 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 1 0 0
minor_off_par 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
read_inj_both 0 0 00 00000000 0000000000 1 04 1 06 1 13579bdf 1 89abcdef 0 0 0
minor_pulse_both 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 1 0 0
minor_off_both 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
inj_double_x7 0 1 07 55aa55aa 0000000003 0 00 0 00 0 00000000 0 00000000 0 0 0
read_double 0 0 00 00000000 0000000000 1 07 0 00 1 00000000 0 00000000 0 0 1
major_rise 0 0 00 00000000 0000000000 0 00 1 01 0 00000000 1 cafef00d 0 1 0
major_hold_read 0 0 00 00000000 0000000000 1 02 1 03 1 a5a5a5a5 1 deadbeef 0 1 0
major_hold_idle 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 0 1 0
reset_clear 1 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
idle_after_clear 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
read_after_clear 0 0 00 00000000 0000000000 1 03 1 1f 1 deadbeef 1 0f0f0f0f 0 0 0
write_x8 0 1 08 11111111 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
write_x9 0 1 09 22222222 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0
b2b_read_x8 0 1 0a 33333333 0000000000 1 08 0 00 1 11111111 0 00000000 0 0 0
b2b_read_x9 0 0 00 00000000 0000000000 1 09 0 00 1 22222222 0 00000000 0 0 0
b2b_read_x10 0 0 00 00000000 0000000000 1 0a 0 00 1 33333333 0 00000000 0 0 0
b2b_read_x1_x8 0 0 00 00000000 0000000000 1 01 1 08 1 cafef00d 1 11111111 0 0 0
idle_end 0 0 00 00000000 0000000000 0 00 0 00 0 00000000 0 00000000 0 0 0

// File: sim/tb_rf_ecc_top.sv
// Trace-driven testbench; the trace file holds exactly two read ports and at most 128 rows
`timescale 1ns/1ps
`include "rf_config.svh"

module tb_rf_ecc_top;

  import rf_pkg::*;

  localparam int    NP         = `RF_NUM_READ_PORTS;
  localparam int    TRACE_MAX  = 128;
  localparam string TRACE_FILE = "sim/rf_ecc_trace.txt";

  // DUT signals
  logic          clk_i;
  logic          rst_i;
  logic          we_i;
  rf_addr_t      waddr_i;
  rf_data_t      wdata_i;
  rf_cword_t     winj_i;
  logic [NP-1:0] re_i;
  rf_addr_t      raddr_i [NP];
  rf_data_t      rdata_o [NP];
  logic [NP-1:0] rvalid_o;
  logic          alert_minor_o;
  logic          alert_major_o;

  // Trace rows with stimulus followed by expectations
  string     tr_name  [TRACE_MAX];
  logic      tr_rst   [TRACE_MAX];
  logic      tr_we    [TRACE_MAX];
  rf_addr_t  tr_waddr [TRACE_MAX];
  rf_data_t  tr_wdata [TRACE_MAX];
  rf_cword_t tr_winj  [TRACE_MAX];
  logic      tr_re    [TRACE_MAX][NP];
  rf_addr_t  tr_raddr [TRACE_MAX][NP];
  logic      tr_v     [TRACE_MAX][NP];
  rf_data_t  tr_d     [TRACE_MAX][NP];
  logic      tr_minor [TRACE_MAX];
  logic      tr_major [TRACE_MAX];
  logic      tr_dc    [TRACE_MAX];

  int          n_rows      = 0;
  int          err_cnt     = 0;
  int          check_cnt   = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = TRACE_MAX + 20;

  rf_ecc_top dut_i (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .we_i          ( we_i          ),
    .waddr_i       ( waddr_i       ),
    .wdata_i       ( wdata_i       ),
    .winj_i        ( winj_i        ),
    .re_i          ( re_i          ),
    .raddr_i       ( raddr_i       ),
    .rdata_o       ( rdata_o       ),
    .rvalid_o      ( rvalid_o      ),
    .alert_minor_o ( alert_minor_o ),
    .alert_major_o ( alert_major_o )
  );

  // 20 ns clock
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string test, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("CHECK FAILED %s %s expected %h actual %h at %0t",
               test, field, expected, actual, $time);
    end
  endtask

  // Skips blank lines and lines that start with '#'
  task automatic load_trace();
    int          fd;
    int          rc;
    int          line_no;
    string       line;
    logic [127:0] name_buf;
    logic        f_rst, f_we, f_re0, f_re1, f_v0, f_v1, f_minor, f_major, f_dc;
    rf_addr_t    f_waddr, f_ra0, f_ra1;
    rf_data_t    f_wdata, f_d0, f_d1;
    rf_cword_t   f_winj;
    line_no = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      err_cnt++;
      $display("ERROR cannot open trace file %s", TRACE_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        if (line.len() > 1 && line[0] != "#") begin
          rc = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       name_buf, f_rst, f_we, f_waddr, f_wdata, f_winj,
                       f_re0, f_ra0, f_re1, f_ra1, f_v0, f_d0, f_v1, f_d1,
                       f_minor, f_major, f_dc);
          if (rc != 17) begin
            err_cnt++;
            $display("ERROR trace line %0d cannot be parsed", line_no);
          end else if (n_rows >= TRACE_MAX) begin
            err_cnt++;
            $display("ERROR trace has more than %0d rows", TRACE_MAX);
          end else begin
            tr_name[n_rows]     = $sformatf("%0s", name_buf);
            tr_rst[n_rows]      = f_rst;
            tr_we[n_rows]       = f_we;
            tr_waddr[n_rows]    = f_waddr;
            tr_wdata[n_rows]    = f_wdata;
            tr_winj[n_rows]     = f_winj;
            tr_re[n_rows][0]    = f_re0;
            tr_raddr[n_rows][0] = f_ra0;
            tr_re[n_rows][1]    = f_re1;
            tr_raddr[n_rows][1] = f_ra1;
            tr_v[n_rows][0]     = f_v0;
            tr_d[n_rows][0]     = f_d0;
            tr_v[n_rows][1]     = f_v1;
            tr_d[n_rows][1]     = f_d1;
            tr_minor[n_rows]    = f_minor;
            tr_major[n_rows]    = f_major;
            tr_dc[n_rows]       = f_dc;
            n_rows++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Applied on a rising edge and sampled by the DUT one edge later
  task automatic drive_row(input int k);
    rst_i   <= tr_rst[k];
    we_i    <= tr_we[k];
    waddr_i <= tr_waddr[k];
    wdata_i <= tr_wdata[k];
    winj_i  <= tr_winj[k];
    for (int p = 0; p < NP; p++) begin
      re_i[p]    <= tr_re[k][p];
      raddr_i[p] <= tr_raddr[k][p];
    end
  endtask

  // Data only matters on a valid result outside a double error
  task automatic check_row(input int k);
    for (int p = 0; p < NP; p++) begin
      check_value(tr_name[k], $sformatf("rvalid%0d", p), 64'(tr_v[k][p]), 64'(rvalid_o[p]));
      if (tr_v[k][p] && !tr_dc[k]) begin
        check_value(tr_name[k], $sformatf("rdata%0d", p), 64'(tr_d[k][p]), 64'(rdata_o[p]));
      end
    end
    check_value(tr_name[k], "alert_minor", 64'(tr_minor[k]), 64'(alert_minor_o));
    check_value(tr_name[k], "alert_major", 64'(tr_major[k]), 64'(alert_major_o));
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("ERROR run stopped after %0d cycles without finishing the trace", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h373a_d992));
    rst_i   = 1'b1;
    we_i    = 1'b0;
    waddr_i = '0;
    wdata_i = '0;
    winj_i  = '0;
    re_i    = '0;
    for (int p = 0; p < NP; p++) begin
      raddr_i[p] = '0;
    end
    load_trace();
    // Trace length plus margin for reset and drain
    cycle_limit = n_rows + 20;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    if (n_rows > 0) drive_row(0);
    // Next row goes out while the previous one is checked
    for (int k = 0; k < n_rows; k++) begin
      @(posedge clk_i);
      if (k + 1 < n_rows) drive_row(k + 1);
      @(negedge clk_i);
      check_row(k);
    end
    $display("%0d rows, %0d checks, %0d errors", n_rows, check_cnt, err_cnt);
    if (err_cnt == 0 && n_rows > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
